/* hdl/macPkg.sv */
// Multiply-accumulate shared definitions

package macPkg;

    // ------------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------------
    localparam int dataWidth = 32;                  // One word
    localparam int accWidth  = 2 * dataWidth;       // HI and LO together
    localparam int halfWidth = dataWidth / 2;       // Split point of operand B

    // Extended A (33 bits) times one 17-bit slice of extended B
    localparam int partWidth = dataWidth + halfWidth + 2;
    localparam int sumWidth  = accWidth + 2;        // Room for the shifted high part

    // ------------------------------------------------------------------------
    // Function codes
    // ------------------------------------------------------------------------
    // MIPS funct values; the SPECIAL2 group sits in the low codes
    typedef enum logic [5:0]
    {
        MADD  = 6'h00,
        MADDU = 6'h01,
        MSUB  = 6'h04,
        MSUBU = 6'h05,
        MFHI  = 6'h10,
        MTHI  = 6'h11,
        MFLO  = 6'h12,
        MTLO  = 6'h13,
        MULT  = 6'h18,
        MULTU = 6'h19
    } macFuncT;

    // ------------------------------------------------------------------------
    // Status flags
    // ------------------------------------------------------------------------
    typedef struct packed
    {
        logic carry;        // Carry or borrow out of bit 63
        logic zero;         // Accumulator is zero
        logic overflow;     // Signed or unsigned overflow
        logic negative;     // Bit 63 of the accumulator
    } macFlagsT;

endpackage

/* hdl/mulIf.sv */
// Multiplier to accumulator link

`timescale 1ns/100ps

interface mulIf;

    import macPkg::*;

    logic                 valid;
    macFuncT              func;
    logic [accWidth-1:0]  product;      // Full 64-bit product
    logic [dataWidth-1:0] operand;      // Operand A for MTHI and MTLO
    logic                 ready;        // Low while a read result waits

    modport source
    (
        output valid,
        output func,
        output product,
        output operand,
        input  ready
    );

    modport sink
    (
        input  valid,
        input  func,
        input  product,
        input  operand,
        output ready
    );

endinterface

/* hdl/mulArray.sv */
// Two-stage 32x32 multiplier

`timescale 1ns/100ps

module mulArray
(
    input  logic                           Clock,
    input  logic                           nReset,
    input  logic                           cmdValid,
    output logic                           cmdReady,
    input  macPkg::macFuncT                cmdFunc,
    input  logic [macPkg::dataWidth-1:0]   cmdA,
    input  logic [macPkg::dataWidth-1:0]   cmdB,
    mulIf.source                           mulOut
);

    import macPkg::*;

    logic                        signedOp;
    logic signed [dataWidth:0]   aExt;
    logic signed [dataWidth:0]   bExt;
    logic signed [partWidth-1:0] partLo;
    logic signed [partWidth-1:0] partHi;
    logic                        advance;

    // Stage one
    logic                        s1Valid;
    macFuncT                     s1Func;
    logic [dataWidth-1:0]        s1A;
    logic signed [partWidth-1:0] s1PartLo;
    logic signed [partWidth-1:0] s1PartHi;

    // Stage two
    logic signed [sumWidth-1:0]  sumFull;
    logic                        s2Valid;
    macFuncT                     s2Func;
    logic [dataWidth-1:0]        s2A;
    logic [accWidth-1:0]         s2Product;

    // ------------------------------------------------------------------------
    // Operand extension and partial products
    // ------------------------------------------------------------------------
    assign signedOp = (cmdFunc == MULT) || (cmdFunc == MADD) || (cmdFunc == MSUB);

    assign aExt = {signedOp & cmdA[dataWidth-1], cmdA};
    assign bExt = {signedOp & cmdB[dataWidth-1], cmdB};

    // Low slice of B is always unsigned, high slice carries the sign
    assign partLo = aExt * $signed({1'b0, bExt[halfWidth-1:0]});
    assign partHi = aExt * $signed(bExt[dataWidth:halfWidth]);

    // Whole pipeline moves in lock step with the sink
    assign advance  = mulOut.ready;
    assign cmdReady = advance;

    // ------------------------------------------------------------------------
    // Valid bits
    // ------------------------------------------------------------------------
    always_ff @(posedge Clock or negedge nReset)
    begin
        if (!nReset)
        begin
            s1Valid <= 1'b0;
            s2Valid <= 1'b0;
        end
        else if (advance)
        begin
            s1Valid <= cmdValid;
            s2Valid <= s1Valid;
        end
    end

    // Sum of the shifted high part and the low part
    assign sumFull = (sumWidth'(s1PartHi) <<< halfWidth) + sumWidth'(s1PartLo);

    // ------------------------------------------------------------------------
    // Payload
    // ------------------------------------------------------------------------
    always_ff @(posedge Clock)
    begin
        if (advance)
        begin
            s1Func    <= cmdFunc;
            s1A       <= cmdA;          // Passed along for MTHI and MTLO
            s1PartLo  <= partLo;
            s1PartHi  <= partHi;

            s2Func    <= s1Func;
            s2A       <= s1A;
            s2Product <= sumFull[accWidth-1:0];
        end
    end

    assign mulOut.valid   = s2Valid;
    assign mulOut.func    = s2Func;
    assign mulOut.product = s2Product;
    assign mulOut.operand = s2A;

endmodule

/* hdl/accControl.sv */
// HI/LO accumulator and flags

`timescale 1ns/100ps

module accControl
(
    input  logic                           Clock,
    input  logic                           nReset,
    mulIf.sink                             mulIn,
    output logic                           resValid,
    input  logic                           resReady,
    output logic [macPkg::dataWidth-1:0]   resData,
    output macPkg::macFlagsT               flags
);

    import macPkg::*;

    logic [accWidth-1:0] acc;
    logic [accWidth-1:0] accNext;
    logic                carryNext;
    logic                overflowNext;
    logic                writeAcc;          // Function changes HI/LO
    logic                readAcc;           // MFHI or MFLO
    logic                take;

    // Stall only while a read result sits unclaimed
    assign mulIn.ready = !(resValid && !resReady);
    assign take        = mulIn.valid && mulIn.ready;

    // ------------------------------------------------------------------------
    // Next accumulator value and flags
    // ------------------------------------------------------------------------
    always_comb
    begin
        accNext      = acc;
        carryNext    = 1'b0;
        overflowNext = 1'b0;
        writeAcc     = 1'b1;
        readAcc      = 1'b0;

        case (mulIn.func)
            MULT, MULTU:
                accNext = mulIn.product;
            MADD, MADDU:
            begin
                {carryNext, accNext} = {1'b0, acc} + {1'b0, mulIn.product};
                if (mulIn.func == MADDU)
                    overflowNext = carryNext;
                else
                    overflowNext = (acc[accWidth-1] == mulIn.product[accWidth-1])
                                && (accNext[accWidth-1] != acc[accWidth-1]);
            end
            MSUB, MSUBU:
            begin
                {carryNext, accNext} = {1'b0, acc} - {1'b0, mulIn.product};   // Borrow
                if (mulIn.func == MSUBU)
                    overflowNext = carryNext;
                else
                    overflowNext = (acc[accWidth-1] != mulIn.product[accWidth-1])
                                && (accNext[accWidth-1] != acc[accWidth-1]);
            end
            MTHI:
                accNext[accWidth-1:dataWidth] = mulIn.operand;
            MTLO:
                accNext[dataWidth-1:0] = mulIn.operand;
            MFHI, MFLO:
            begin
                writeAcc = 1'b0;
                readAcc  = 1'b1;
            end
            default:
                writeAcc = 1'b0;            // Unknown code is dropped
        endcase
    end

    // ------------------------------------------------------------------------
    // Accumulator, flags and result valid
    // ------------------------------------------------------------------------
    always_ff @(posedge Clock or negedge nReset)
    begin
        if (!nReset)
        begin
            acc      <= '0;
            flags    <= '0;
            resValid <= 1'b0;
        end
        else
        begin
            if (take && writeAcc)
            begin
                acc            <= accNext;
                flags.carry    <= carryNext;
                flags.zero     <= (accNext == '0);
                flags.overflow <= overflowNext;
                flags.negative <= accNext[accWidth-1];
            end

            // New read wins over the retiring one
            if (take && readAcc)
                resValid <= 1'b1;
            else if (resReady)
                resValid <= 1'b0;
        end
    end

    // Selected half as it stands on the consuming edge
    always_ff @(posedge Clock)
    begin
        if (take && readAcc)
            resData <= (mulIn.func == MFHI) ? acc[accWidth-1:dataWidth] : acc[dataWidth-1:0];
    end

endmodule

/* hdl/macUnit.sv */
// Multiply-accumulate unit top level

`timescale 1ns/100ps

module macUnit
(
    input  logic                           Clock,
    input  logic                           nReset,

    // Command channel
    input  logic                           cmdValid,
    output logic                           cmdReady,
    input  macPkg::macFuncT                cmdFunc,
    input  logic [macPkg::dataWidth-1:0]   cmdA,
    input  logic [macPkg::dataWidth-1:0]   cmdB,

    // Result channel
    output logic                           resValid,
    input  logic                           resReady,
    output logic [macPkg::dataWidth-1:0]   resData,

    output macPkg::macFlagsT               flags
);

    // ------------------------------------------------------------------------
    // Multiplier into accumulator
    // ------------------------------------------------------------------------
    mulIf mulBus ();

    mulArray uMulArray
    (
        .Clock    (Clock),
        .nReset   (nReset),
        .cmdValid (cmdValid),
        .cmdReady (cmdReady),
        .cmdFunc  (cmdFunc),
        .cmdA     (cmdA),
        .cmdB     (cmdB),
        .mulOut   (mulBus.source)
    );

    accControl uAccControl
    (
        .Clock    (Clock),
        .nReset   (nReset),
        .mulIn    (mulBus.sink),
        .resValid (resValid),
        .resReady (resReady),
        .resData  (resData),
        .flags    (flags)       // Registered inside
    );

endmodule

/* testbench/macUnit_assert.sv */
// MAC unit handshake assertions

`timescale 1ns/100ps

module macUnitAssert
(
    input logic                           Clock,
    input logic                           nReset,
    input logic                           cmdReady,
    input logic                           resValid,
    input logic                           resReady,
    input logic [macPkg::dataWidth-1:0]   resData,
    input macPkg::macFlagsT               flags
);

    // Waiting result holds its data until taken
    property resultHeld;
        @(posedge Clock) disable iff (!nReset)
            resValid && !resReady |=> resValid && $stable(resData);
    endproperty

    property readyFollowsStall;
        @(posedge Clock) disable iff (!nReset)
            cmdReady == !(resValid && !resReady);
    endproperty

    property flagsKnown;
        @(posedge Clock) disable iff (!nReset)
            !$isunknown(flags);
    endproperty

    assert property (resultHeld)
        else $error("Result dropped or changed before resReady");
    assert property (readyFollowsStall)
        else $error("cmdReady does not follow the result stall");
    assert property (flagsKnown)
        else $error("Flags hold unknown bits");

endmodule

bind macUnit macUnitAssert uAssert
(
    .Clock    (Clock),
    .nReset   (nReset),
    .cmdReady (cmdReady),
    .resValid (resValid),
    .resReady (resReady),
    .resData  (resData),
    .flags    (flags)
);

/* testbench/macUnitTb.sv */
// MAC unit testbench

`timescale 1ns/100ps

module macUnitTb;

    import macPkg::*;

    logic                 Clock;
    logic                 nReset;
    logic                 cmdValid;
    logic                 cmdReady;
    macFuncT              cmdFunc;
    logic [dataWidth-1:0] cmdA;
    logic [dataWidth-1:0] cmdB;
    logic                 resValid;
    logic                 resReady;
    logic [dataWidth-1:0] resData;
    macFlagsT             flags;

    logic [31:0]          cmdLfsr;          // Functions, operands and gaps
    logic [31:0]          stallLfsr;        // resReady stalls
    logic                 stallEnable;
    logic                 stallNow;
    logic [accWidth-1:0]  modelAcc;
    macFlagsT             modelFlags;
    logic [dataWidth-1:0] expData[$];       // Pending reads in command order
    macFlagsT             expFlags[$];
    macFuncT              expFunc[$];
    macFuncT              headFunc;
    int                   dataErrors;
    int                   flagErrors;
    int                   protocolErrors;
    int                   timeouts;

    macFuncT funcTable[10] = '{MULT, MULTU, MADD, MADDU, MSUB, MSUBU, MTHI, MTLO, MFHI, MFLO};

    macUnit UUT
    (
        .Clock    (Clock),
        .nReset   (nReset),
        .cmdValid (cmdValid),
        .cmdReady (cmdReady),
        .cmdFunc  (cmdFunc),
        .cmdA     (cmdA),
        .cmdB     (cmdB),
        .resValid (resValid),
        .resReady (resReady),
        .resData  (resData),
        .flags    (flags)
    );

    always #4 Clock = ~Clock;

    // ------------------------------------------------------------------------
    // Random bits and reference model
    // ------------------------------------------------------------------------
    // Galois LFSR for x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] takeBits(inout logic [31:0] state, input int count);
        logic [31:0] bits;
        int          i;
        bits = '0;
        for (i = 0; i < count; i++)
        begin
            bits  = {bits[30:0], state[0]};
            state = state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
        end
        return bits;
    endfunction

    function automatic void applyModel(input macFuncT func, input logic [31:0] a,
                                       input logic [31:0] b);
        logic [accWidth-1:0] product;
        logic [accWidth-1:0] next;
        logic                carry;
        logic                ovf;
        if ((func == MULT) || (func == MADD) || (func == MSUB))
            product = longint'($signed(a)) * longint'($signed(b));
        else
            product = {32'b0, a} * {32'b0, b};
        next  = modelAcc;
        carry = 1'b0;
        ovf   = 1'b0;
        case (func)
            MULT, MULTU:
                next = product;
            MADD, MADDU:
            begin
                {carry, next} = {1'b0, modelAcc} + {1'b0, product};
                ovf = (func == MADDU) ? carry
                    : (modelAcc[63] == product[63]) && (next[63] != product[63]);
            end
            MSUB, MSUBU:
            begin
                {carry, next} = {1'b0, modelAcc} - {1'b0, product};  // Borrow
                ovf = (func == MSUBU) ? carry
                    : (modelAcc[63] != product[63]) && (next[63] != modelAcc[63]);
            end
            MTHI:
                next[63:32] = a;
            MTLO:
                next[31:0] = a;
            default:
            begin
                // Reads leave the accumulator and flags alone
                expData.push_back((func == MFHI) ? modelAcc[63:32] : modelAcc[31:0]);
                expFlags.push_back(modelFlags);
                expFunc.push_back(func);
                return;
            end
        endcase
        modelAcc            = next;
        modelFlags.carry    = carry;
        modelFlags.zero     = (next == '0);
        modelFlags.overflow = ovf;
        modelFlags.negative = next[63];
    endfunction

    // ------------------------------------------------------------------------
    // Compare tasks and run end
    // ------------------------------------------------------------------------
    task automatic checkData(input logic [dataWidth-1:0] got, input logic [dataWidth-1:0] exp,
                             input string what);
        if (got !== exp)
        begin
            dataErrors++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkFlags(input macFlagsT got, input macFlagsT exp, input string what);
        if (got !== exp)
        begin
            flagErrors++;
            $display("CHECK FAILED at %0t: %s are %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic finishRun();
        int total;
        total = dataErrors + flagErrors + protocolErrors + timeouts;
        $display("Errors: %0d data, %0d flags, %0d protocol, %0d timeouts",
                 dataErrors, flagErrors, protocolErrors, timeouts);
        if (total == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    endtask

    // ------------------------------------------------------------------------
    // Command and drain tasks
    // ------------------------------------------------------------------------
    task automatic sendCommand(input macFuncT func, input logic [31:0] a, input logic [31:0] b);
        int   waited;
        logic accepted;
        waited   = 0;
        accepted = 1'b0;
        cmdValid = 1'b1;
        cmdFunc  = func;
        cmdA     = a;
        cmdB     = b;
        while (!accepted && (timeouts == 0))
        begin
            @(negedge Clock);
            if (cmdReady)
                accepted = 1'b1;    // Taken on the coming edge
            else if (waited == 1000)
            begin
                timeouts++;
                $display("Command %s was never accepted, cmdReady stuck low", func.name());
            end
            waited++;
            @(posedge Clock);
            #1;
        end
        cmdValid = 1'b0;
    endtask

    task automatic idleCycles(input int count);
        repeat (count)
        begin
            @(posedge Clock);
            #1;
        end
    endtask

    task automatic drainResults();
        int waited;
        waited      = 0;
        stallEnable = 1'b0;
        while (((expData.size() != 0) || resValid) && (timeouts == 0))
        begin
            if (waited == 1000)
            begin
                timeouts++;
                $display("Results still pending after %0d cycles", waited);
            end
            waited++;
            @(posedge Clock);
            #1;
        end
    endtask

    // Stall pattern picked at the edge, driven just after it
    always @(posedge Clock)
    begin
        stallNow = stallEnable;
        #1;
        resReady = stallNow ? (takeBits(stallLfsr, 2) != 0) : 1'b1;
    end

    // Transfers are stable here and happen on the next rising edge
    always @(negedge Clock)
    begin
        if (nReset && resValid && resReady)
        begin
            if (expData.size() == 0)
            begin
                protocolErrors++;
                $display("Result %h arrived at %0t with no read pending", resData, $time);
            end
            else
            begin
                headFunc = expFunc.pop_front();
                checkData(resData, expData.pop_front(), $sformatf("%s data", headFunc.name()));
                checkFlags(flags, expFlags.pop_front(), $sformatf("%s flags", headFunc.name()));
            end
        end
        if (nReset && cmdValid && cmdReady)
        begin
            applyModel(cmdFunc, cmdA, cmdB);
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    initial
    begin
        Clock       = 1'b0;
        nReset      = 1'b0;
        cmdValid    = 1'b0;
        cmdFunc     = MFLO;
        cmdA        = '0;
        cmdB        = '0;
        resReady    = 1'b1;
        stallEnable = 1'b0;
        cmdLfsr     = 32'h794f_057d;
        stallLfsr   = 32'h794f_057d;
        modelAcc    = '0;
        modelFlags  = '0;
        repeat (4) @(posedge Clock);
        #1;
        nReset = 1'b1;

        sendCommand(MFLO, '0, '0);          // Reset state
        sendCommand(MFHI, '0, '0);

        repeat (20)
        begin
            sendCommand(funcTable[takeBits(cmdLfsr, 1)], takeBits(cmdLfsr, 32),
                        takeBits(cmdLfsr, 32));
            sendCommand(MFHI, '0, '0);
            sendCommand(MFLO, '0, '0);
        end

        // Signed overflow, unsigned carry, unsigned borrow, MSUB overflow
        sendCommand(MTHI, 32'h7fff_ffff, '0);
        sendCommand(MTLO, 32'hffff_ffff, '0);
        sendCommand(MADD, 32'd1, 32'd1);
        sendCommand(MFHI, '0, '0);
        sendCommand(MTHI, 32'hffff_ffff, '0);
        sendCommand(MTLO, 32'hffff_ffff, '0);
        sendCommand(MADDU, 32'd1, 32'd1);
        sendCommand(MFLO, '0, '0);
        sendCommand(MULTU, '0, '0);
        sendCommand(MSUBU, 32'd2, 32'd3);
        sendCommand(MFLO, '0, '0);
        sendCommand(MTHI, 32'h8000_0000, '0);
        sendCommand(MTLO, '0, '0);
        sendCommand(MSUB, 32'd1, 32'd1);
        sendCommand(MFHI, '0, '0);

        repeat (40)
        begin
            sendCommand(funcTable[2 + takeBits(cmdLfsr, 2)], takeBits(cmdLfsr, 32),
                        takeBits(cmdLfsr, 32));
            if (takeBits(cmdLfsr, 2) == 0)
                sendCommand(MFHI, '0, '0);
        end
        sendCommand(MFLO, '0, '0);

        // Half writes then a merged MADD
        sendCommand(MULT, takeBits(cmdLfsr, 32), takeBits(cmdLfsr, 32));
        sendCommand(MTHI, takeBits(cmdLfsr, 32), '0);
        sendCommand(MFLO, '0, '0);
        sendCommand(MFHI, '0, '0);
        sendCommand(MTLO, takeBits(cmdLfsr, 32), '0);
        sendCommand(MFHI, '0, '0);
        sendCommand(MFLO, '0, '0);
        sendCommand(MADD, takeBits(cmdLfsr, 32), takeBits(cmdLfsr, 32));
        sendCommand(MFHI, '0, '0);
        sendCommand(MFLO, '0, '0);

        stallEnable = 1'b1;
        repeat (150)
        begin
            sendCommand(funcTable[takeBits(cmdLfsr, 4) % 10], takeBits(cmdLfsr, 32),
                        takeBits(cmdLfsr, 32));
            if (takeBits(cmdLfsr, 1))
                idleCycles(takeBits(cmdLfsr, 2));
        end

        drainResults();
        finishRun();
    end

endmodule

/* sim.f */
hdl/macPkg.sv
hdl/mulIf.sv
hdl/mulArray.sv
hdl/accControl.sv
hdl/macUnit.sv
testbench/macUnit_assert.sv
testbench/macUnitTb.sv

/* Makefile */
SOURCES := $(wildcard hdl/*.sv testbench/*.sv)

.PHONY: run clean

run: obj_dir/VmacUnitTb
	@out=$$(./obj_dir/VmacUnitTb); echo "$$out"; echo "$$out" | grep -qx 'Regression passed'

obj_dir/VmacUnitTb: sim.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		--top-module macUnitTb -f sim.f

clean:
	rm -rf obj_dir
